/* comp_pkg.sv */
`include "sub2tlul_macros.svh"

package comp_pkg;

    // -----------------------------------------------------------------------
    // Component bus
    // -----------------------------------------------------------------------

    // Request from the component
    // All fields stay stable while hld is high
    typedef struct packed {
        logic                      dv;     // Access strobe
        logic                      write;  // 1 for write, 0 for read
        logic [`SUB_AW-1:0]        addr;   // Byte address
        logic [`SUB_IW-1:0]        id;     // Echoed back as TL-UL source
        logic [`SUB_DW-1:0]        wdata;
        logic [`SUB_DW/8-1:0]      wstrb;  // Byte enables for writes
        logic [1:0]                size;   // log2 of bytes in beat
    } comp_req_t;

    // Response to the component
    // Valid in the cycle where dv is high and hld is low
    typedef struct packed {
        logic [`SUB_DW-1:0]        rdata;  // Zero unless a read completes
        logic                      hld;    // Back-pressure on the request
        logic                      rd_err;
        logic                      wr_err;
    } comp_rsp_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_sub2tlul \
    -f verilog.f \
    -o sim_tb

# Error limit keeps the run going so the summary is printed
./obj_dir/sim_tb +verilator+error+limit+1000 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED, see sim.log"
    exit 1
fi

/* sub2tlul.sv */
`timescale 1ns/1ps

`include "sub2tlul_macros.svh"

module sub2tlul (
    input  logic                 clk,
    input  logic                 rst_n,

    // Component side
    input  comp_pkg::comp_req_t  req_i,
    output comp_pkg::comp_rsp_t  rsp_o,

    // TL-UL host side
    output tlul_pkg::tl_h2d_t    tl_o,
    input  tlul_pkg::tl_d2h_t    tl_i
);

    import tlul_pkg::*;

    // Outstanding transaction, one at most
    typedef enum logic [1:0] {
        no_txn  = 2'b00,
        get_txn = 2'b01,
        put_txn = 2'b10
    } txn_state_e;

    txn_state_e           cur_txn;
    tl_a_op_e             opcode;
    logic [`SUB_DW/8-1:0] mask;
    logic                 a_valid;
    logic                 a_fire;       // Request accepted this edge
    logic                 d_fire;       // Response taken this edge
    logic                 id_match;
    logic                 rsp_get;      // Read response for our access
    logic                 rsp_put;      // Write ack for our access

    cmd_payload_t         cmd_pl;
    data_payload_t        data_pl;
    logic [`INTG_W-1:0]   cmd_intg;
    logic [`INTG_W-1:0]   data_intg;

    // ---------------------------------------------------------------------------
    // Request decode
    // ---------------------------------------------------------------------------

    assign opcode = !req_i.write      ? Get :
                    (req_i.wstrb == '1) ? PutFullData : PutPartialData;
    assign mask   = req_i.write ? req_i.wstrb : '1;  // Reads fetch the whole word

    // Only offer a request when nothing is in flight
    assign a_valid = req_i.dv & (cur_txn == no_txn);
    assign a_fire  = a_valid & tl_i.a_ready;
    assign d_fire  = tl_i.d_valid;              // d_ready follows d_valid

    // ---------------------------------------------------------------------------
    // Transaction tracking
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_txn <= no_txn;
        end else if (a_fire) begin
            cur_txn <= req_i.write ? put_txn : get_txn;  // Hold the write flag
        end else if (d_fire) begin
            cur_txn <= no_txn;
        end
    end

    // ---------------------------------------------------------------------------
    // Integrity
    // ---------------------------------------------------------------------------

    assign cmd_pl.opcode  = opcode;
    assign cmd_pl.address = req_i.addr;
    assign cmd_pl.mask    = mask;
    assign data_pl.data   = req_i.wdata;

    tlul_intg_enc #(.payload_t(cmd_payload_t)) u_cmd_intg (
        .data_i (cmd_pl),
        .intg_o (cmd_intg)
    );

    tlul_intg_enc #(.payload_t(data_payload_t)) u_data_intg (
        .data_i (data_pl),
        .intg_o (data_intg)
    );

    // A channel out
    always_comb begin
        tl_o.a_valid     = a_valid;
        tl_o.a_opcode    = opcode;
        tl_o.a_size      = req_i.size;
        tl_o.a_source    = req_i.id;
        tl_o.a_address   = req_i.addr;
        tl_o.a_mask      = mask;
        tl_o.a_data      = req_i.wdata;
        tl_o.a_cmd_intg  = cmd_intg;
        tl_o.a_data_intg = data_intg;
        tl_o.d_ready     = tl_i.d_valid;  // No response back-pressure
    end

    // ---------------------------------------------------------------------------
    // Response
    // ---------------------------------------------------------------------------

    assign id_match = tl_i.d_valid & (tl_i.d_source == req_i.id);
    assign rsp_get  = id_match & (cur_txn == get_txn) & (tl_i.d_opcode == AccessAckData);
    assign rsp_put  = id_match & (cur_txn == put_txn) & (tl_i.d_opcode == AccessAck);

    always_comb begin
        rsp_o.rdata  = rsp_get ? tl_i.d_data : '0;
        rsp_o.hld    = req_i.dv & ~(rsp_get | rsp_put);  // Stall until our response
        rsp_o.rd_err = rsp_get & tl_i.d_error;
        rsp_o.wr_err = rsp_put & tl_i.d_error;
    end

endmodule

/* sub2tlul_macros.svh */
`ifndef SUB2TLUL_MACROS_SVH
`define SUB2TLUL_MACROS_SVH

// ---------------------------------------------------------------------------
// Bus geometry
// ---------------------------------------------------------------------------

// Byte address width on both the component side and the TL-UL side
`define SUB_AW 32

// Data width of a single beat
`define SUB_DW 32

// Component ID width, carried as a_source on TL-UL
`define SUB_IW 2

// ---------------------------------------------------------------------------
// Device and integrity
// ---------------------------------------------------------------------------

// Number of 32-bit words behind the TL-UL device
`define SRAM_WORDS 64

// Folded parity code width
// Bit k covers every payload bit whose index mod INTG_W equals k
`define INTG_W 7

`endif

/* sub2tlul_props.sv */
`timescale 1ns/1ps

`include "sub2tlul_macros.svh"

// Component-side checks for the bridge and SRAM pair, with a byte shadow of the SRAM
module sub2tlul_props (
    input logic                 clk,
    input logic                 rst_n,
    input comp_pkg::comp_req_t  req_i,
    input comp_pkg::comp_rsp_t  rsp_i
);

    localparam int BC   = `SUB_DW / 8;
    localparam int IDXW = $clog2(`SRAM_WORDS);

    logic [7:0]          shadow [`SRAM_WORDS * BC];  // Expected SRAM bytes
    logic [`SUB_AW-3:0]  word;
    logic [IDXW-1:0]     idx;
    logic                in_range;
    logic                done;                       // Access completes on this edge
    logic [`SUB_DW-1:0]  shadow_word;
    int                  fail_cnt = 0;               // Read by the testbench

    assign word     = req_i.addr[`SUB_AW-1:2];
    assign idx      = word[IDXW-1:0];
    assign in_range = (word < `SRAM_WORDS);
    assign done     = rst_n & req_i.dv & ~rsp_i.hld;

    always_comb begin
        for (int b = 0; b < BC; b++) begin
            shadow_word[8*b +: 8] = shadow[idx * BC + b];
        end
    end

    // Follow completed in-range writes byte by byte
    always_ff @(posedge clk) begin
        if (done && req_i.write && in_range) begin
            for (int b = 0; b < BC; b++) begin
                if (req_i.wstrb[b]) shadow[idx * BC + b] <= req_i.wdata[8*b +: 8];
            end
        end
    end

    // -------------------------------------------------------------------------
    // Properties
    // -------------------------------------------------------------------------

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !req_i.dv |-> !rsp_i.hld && !rsp_i.rd_err && !rsp_i.wr_err)
    else begin
        $error("FAILED at %0t: hld or error strobe active with dv low", $time);
        fail_cnt++;
    end

    // One hold cycle, completion on the second edge
    a_timing: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(req_i.dv) |-> rsp_i.hld ##1 (req_i.dv && !rsp_i.hld))
    else begin
        $error("FAILED at %0t: access did not complete two cycles after dv", $time);
        fail_cnt++;
    end

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        done && !req_i.write && in_range |-> rsp_i.rdata == shadow_word)
    else begin
        $error("FAILED at %0t: read data %h, shadow holds %h", $time, rsp_i.rdata, shadow_word);
        fail_cnt++;
    end

    a_no_err: assert property (@(posedge clk) disable iff (!rst_n)
        done && in_range |-> !rsp_i.rd_err && !rsp_i.wr_err)
    else begin
        $error("FAILED at %0t: error strobe on in-range access %h", $time, req_i.addr);
        fail_cnt++;
    end

    // Out of range: matching strobe only, and reads come back as zero
    a_range: assert property (@(posedge clk) disable iff (!rst_n)
        done && !in_range |-> (req_i.write ? (rsp_i.wr_err && !rsp_i.rd_err) :
                               (rsp_i.rd_err && !rsp_i.wr_err && rsp_i.rdata == '0)))
    else begin
        $error("FAILED at %0t: wrong range error response at %h", $time, req_i.addr);
        fail_cnt++;
    end

endmodule

/* sub2tlul_sram_top.sv */
`timescale 1ns/1ps

module sub2tlul_sram_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // Component bus
    input  comp_pkg::comp_req_t  req_i,
    output comp_pkg::comp_rsp_t  rsp_o
);

    import tlul_pkg::*;

    // ---------------------------------------------------------------------------
    // Internal TL-UL link
    // ---------------------------------------------------------------------------

    tl_h2d_t tl_h2d;   // Bridge to device
    tl_d2h_t tl_d2h;   // Device to bridge

    // Component to TL-UL host
    sub2tlul u_sub2tlul (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (req_i),
        .rsp_o (rsp_o),
        .tl_o  (tl_h2d),
        .tl_i  (tl_d2h)
    );

    // TL-UL memory device
    tlul_sram u_tlul_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .tl_i  (tl_h2d),
        .tl_o  (tl_d2h)
    );

endmodule

/* tb_sub2tlul.sv */
`timescale 1ns/1ps

`include "sub2tlul_macros.svh"

module tb_sub2tlul;

    import comp_pkg::*;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 16;
    localparam int N_READ      = 40;   // Random reads after the fill
    localparam int N_PARTIAL   = 20;   // Partial write and read-back pairs
    localparam int N_RANGE     = 16;   // Out-of-range write and read pairs
    localparam int N_ACCESS    = 2 * `SRAM_WORDS + N_READ + 2 * N_PARTIAL + 2 * N_RANGE;
    localparam int WATCHDOG_NS = (RST_CYCLES + 20 + 100 * N_ACCESS) * CLK_PERIOD;
    localparam logic [`SUB_AW-3:0] LIM_WORD = `SRAM_WORDS;  // First word past the SRAM

    logic       clk;
    logic       rst_n;
    comp_req_t  req;
    comp_rsp_t  rsp;
    integer     seed = 32'h22194422;
    int         tests_run = 0;
    int         stall_cnt = 0;         // Accesses stuck on hld

    sub2tlul_sram_top dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (req),
        .rsp_o (rsp)
    );

    bind sub2tlul_sram_top sub2tlul_props u_props (
        .clk   (clk),
        .rst_n (rst_n),
        .req_i (req_i),
        .rsp_i (rsp_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog sized from the planned number of accesses
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        next_rand = $random(seed);
    endfunction

    // Word-aligned address inside the SRAM
    function automatic logic [`SUB_AW-1:0] addr_in(input logic [31:0] r);
        addr_in = {r[`SUB_AW-1:2] % LIM_WORD, 2'b00};
    endfunction

    function automatic logic [`SUB_AW-1:0] addr_out(input logic [31:0] r);
        addr_out = {r[`SUB_AW-1:2] | LIM_WORD, 2'b00};  // Word index >= SRAM_WORDS
    endfunction

    // -------------------------------------------------------------------------
    // One component access that returns after the completion edge
    // -------------------------------------------------------------------------

    task automatic do_access(input logic wr, input logic [`SUB_AW-1:0] addr,
                             input logic [`SUB_DW-1:0] wdata,
                             input logic [`SUB_DW/8-1:0] strb);
        logic [31:0] r;
        int          waited;
        logic        done;
        r      = next_rand();
        waited = 0;
        done   = 1'b0;
        @(posedge clk);
        #1;
        req.dv    = 1'b1;
        req.write = wr;
        req.addr  = addr;
        req.id    = r[`SUB_IW-1:0];   // Random source ID
        req.wdata = wdata;
        req.wstrb = strb;
        req.size  = 2'd2;
        while (!done && waited < 20) begin
            @(negedge clk);             // hld is settled mid-cycle
            waited++;
            done = !rsp.hld;
        end
        if (!done) begin
            $display("Access to %h stayed on hold for %0d cycles", addr, waited);
            stall_cnt++;
        end
        @(posedge clk);                 // Completion edge
        #1;
        req.dv = 1'b0;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("Test %0d %s finished at %0t, assertion failures so far: %0d",
                 tests_run, name, $time, dut_i.u_props.fail_cnt);
    endtask

    initial begin
        logic [31:0]         r;
        logic [`SUB_AW-1:0]  a;
        req   = '0;
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (10) @(posedge clk);     // Bus idle with dv low
        end_test("reset_idle");

        // Fill every word so the shadow is fully known
        for (int i = 0; i < `SRAM_WORDS; i++) begin
            do_access(1'b1, addr_in(i << 2), next_rand(), '1);
        end
        end_test("full_write_fill");

        for (int i = 0; i < N_READ; i++) begin
            do_access(1'b0, addr_in(next_rand()), '0, '0);
        end
        end_test("random_read");

        // Random strobes and then a read-back of the same word
        for (int i = 0; i < N_PARTIAL; i++) begin
            r = next_rand();
            a = addr_in(next_rand());
            do_access(1'b1, a, next_rand(), r[`SUB_DW/8-1:0]);
            do_access(1'b0, a, '0, '0);
        end
        end_test("partial_write");

        // First pair hits the exact boundary
        for (int i = 0; i < N_RANGE; i++) begin
            r = next_rand();
            a = (i == 0) ? {LIM_WORD, 2'b00} : addr_out(next_rand());
            do_access(1'b1, a, next_rand(), r[`SUB_DW/8-1:0]);
            do_access(1'b0, a, '0, '0);
        end
        end_test("range_error");

        // Aliased words must be untouched by the failed writes
        for (int i = 0; i < `SRAM_WORDS; i++) begin
            do_access(1'b0, addr_in(i << 2), '0, '0);
        end
        end_test("final_readback");

        repeat (2) @(posedge clk);
        $display("Summary: %0d tests, %0d assertion failures, %0d stalled accesses",
                 tests_run, dut_i.u_props.fail_cnt, stall_cnt);
        if (dut_i.u_props.fail_cnt == 0 && stall_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tlul_intg_enc.sv */
`timescale 1ns/1ps

`include "sub2tlul_macros.svh"

// Folded parity code over an arbitrary packed payload
// Check bit k is the XOR of all payload bits with index mod INTG_W == k
module tlul_intg_enc #(
    parameter type payload_t = logic [31:0]
) (
    input  payload_t              data_i,
    output logic [`INTG_W-1:0]    intg_o
);

    localparam int PW = $bits(payload_t);  // Payload width in bits

    logic [PW-1:0]      flat;               // Payload as a plain vector
    logic [`INTG_W-1:0] fold;

    assign flat = data_i;

    // ---------------------------------------------------------------------------
    // Fold loop
    // ---------------------------------------------------------------------------

    always_comb begin
        fold = '0;
        for (int i = 0; i < PW; i++) begin
            fold[i % `INTG_W] = fold[i % `INTG_W] ^ flat[i];  // Bucket by index
        end
    end

    assign intg_o = fold;

endmodule

/* tlul_pkg.sv */
`include "sub2tlul_macros.svh"

package tlul_pkg;

    // -----------------------------------------------------------------------
    // Opcodes
    // -----------------------------------------------------------------------

    // A channel request opcodes (TL-UL encoding)
    typedef enum logic [2:0] {
        PutFullData    = 3'h0,
        PutPartialData = 3'h1,
        Get            = 3'h4
    } tl_a_op_e;

    // D channel response opcodes
    typedef enum logic [2:0] {
        AccessAck     = 3'h0,  // Write ack, no data
        AccessAckData = 3'h1   // Read ack with data
    } tl_d_op_e;

    // -----------------------------------------------------------------------
    // Channel structs
    // -----------------------------------------------------------------------

    // Host to device: A channel plus d_ready
    typedef struct packed {
        logic                      a_valid;
        tl_a_op_e                  a_opcode;
        logic [1:0]                a_size;       // log2 of bytes in beat
        logic [`SUB_IW-1:0]        a_source;
        logic [`SUB_AW-1:0]        a_address;
        logic [`SUB_DW/8-1:0]      a_mask;
        logic [`SUB_DW-1:0]        a_data;
        logic [`INTG_W-1:0]        a_cmd_intg;   // Over cmd_payload_t
        logic [`INTG_W-1:0]        a_data_intg;  // Over data_payload_t
        logic                      d_ready;
    } tl_h2d_t;

    // Device to host: a_ready plus D channel
    typedef struct packed {
        logic                      a_ready;
        logic                      d_valid;
        tl_d_op_e                  d_opcode;
        logic [`SUB_IW-1:0]        d_source;
        logic [`SUB_DW-1:0]        d_data;
        logic                      d_error;
    } tl_d2h_t;

    // -----------------------------------------------------------------------
    // Integrity payloads
    // -----------------------------------------------------------------------

    // Command fields protected by a_cmd_intg
    typedef struct packed {
        tl_a_op_e                  opcode;
        logic [`SUB_AW-1:0]        address;
        logic [`SUB_DW/8-1:0]      mask;
    } cmd_payload_t;

    // Write data protected by a_data_intg
    typedef struct packed {
        logic [`SUB_DW-1:0]        data;
    } data_payload_t;

endpackage

/* tlul_sram.sv */
`timescale 1ns/1ps

`include "sub2tlul_macros.svh"

module tlul_sram (
    input  logic               clk,
    input  logic               rst_n,
    input  tlul_pkg::tl_h2d_t  tl_i,
    output tlul_pkg::tl_d2h_t  tl_o
);

    import tlul_pkg::*;

    localparam int BC   = `SUB_DW / 8;            // Bytes per word
    localparam int IDXW = $clog2(`SRAM_WORDS);    // Storage index width

    logic [`SUB_DW-1:0]   mem [`SRAM_WORDS];

    cmd_payload_t         cmd_pl;
    data_payload_t        data_pl;
    logic [`INTG_W-1:0]   cmd_intg;      // Recomputed codes
    logic [`INTG_W-1:0]   data_intg;

    logic [`SUB_AW-3:0]   word;          // Word index from the byte address
    logic [IDXW-1:0]      idx;
    logic                 in_range;
    logic                 is_get;
    logic                 is_put;
    logic                 intg_err;
    logic                 err;
    logic                 a_fire;

    // Response registers
    logic                 d_valid_q;
    tl_d_op_e             d_opcode_q;
    logic [`SUB_IW-1:0]   d_source_q;
    logic [`SUB_DW-1:0]   d_data_q;
    logic                 d_error_q;

    // ---------------------------------------------------------------------------
    // Integrity check
    // ---------------------------------------------------------------------------

    assign cmd_pl.opcode  = tl_i.a_opcode;
    assign cmd_pl.address = tl_i.a_address;
    assign cmd_pl.mask    = tl_i.a_mask;
    assign data_pl.data   = tl_i.a_data;

    tlul_intg_enc #(.payload_t(cmd_payload_t)) u_cmd_chk (
        .data_i (cmd_pl),
        .intg_o (cmd_intg)
    );

    tlul_intg_enc #(.payload_t(data_payload_t)) u_data_chk (
        .data_i (data_pl),
        .intg_o (data_intg)
    );

    assign is_get   = (tl_i.a_opcode == Get);
    assign is_put   = (tl_i.a_opcode == PutFullData) | (tl_i.a_opcode == PutPartialData);
    // Data code only matters when data is written
    assign intg_err = (cmd_intg != tl_i.a_cmd_intg) |
                      (is_put & (data_intg != tl_i.a_data_intg));

    // ---------------------------------------------------------------------------
    // Decode and accept
    // ---------------------------------------------------------------------------

    assign word     = tl_i.a_address[`SUB_AW-1:2];
    assign in_range = (word < `SRAM_WORDS);
    assign idx      = word[IDXW-1:0];
    assign err      = intg_err | ~in_range;
    assign a_fire   = tl_i.a_valid & ~d_valid_q;  // Blocked while a response waits

    // Masked write, dropped on any error
    always_ff @(posedge clk) begin
        if (a_fire && is_put && !err) begin
            for (int b = 0; b < BC; b++) begin
                if (tl_i.a_mask[b]) mem[idx][8*b +: 8] <= tl_i.a_data[8*b +: 8];
            end
        end
    end

    // ---------------------------------------------------------------------------
    // Response channel
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid_q <= 1'b0;
        end else if (a_fire) begin
            d_valid_q <= 1'b1;              // One cycle after acceptance
        end else if (tl_i.d_ready) begin
            d_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (a_fire) begin
            d_opcode_q <= is_get ? AccessAckData : AccessAck;
            d_source_q <= tl_i.a_source;   // Echo source
            d_error_q  <= err;
            d_data_q   <= (is_get && !err) ? mem[idx] : '0;  // Zero on failed read
        end
    end

    always_comb begin
        tl_o.a_ready  = ~d_valid_q;
        tl_o.d_valid  = d_valid_q;
        tl_o.d_opcode = d_opcode_q;
        tl_o.d_source = d_source_q;
        tl_o.d_data   = d_data_q;
        tl_o.d_error  = d_error_q;
    end

endmodule

/* verilog.f */
+incdir+.
tlul_pkg.sv
comp_pkg.sv
tlul_intg_enc.sv
sub2tlul.sv
tlul_sram.sv
sub2tlul_sram_top.sv
sub2tlul_props.sv
tb_sub2tlul.sv
